/* dv/l1d_tb.sv */
/*
 * Testbench of the l1d data cache. Drives the CPU port of l1d_top, models
 * a word memory with random wait states and checks data, hit flags, beat
 * counts and the handshake rules with assertions.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_tb;
  import l1d_pkg::*;

  // A miss costs at most 16 beats of 6 cycles, and the run has well under
  // a hundred misses plus 300 short writes and hits, about 10000 cycles
  localparam int CYCLE_LIMIT = 20000;
  localparam int RAND_OPS    = 300;

  logic        clk;
  logic        rst_n;
  logic        cpu_rd;
  logic        cpu_wr;
  logic [31:0] cpu_adr;
  logic [31:0] cpu_wdata;
  logic        cpu_inv;
  logic        busy;
  logic        cpu_ack;
  logic [31:0] cpu_rdata;
  logic        cpu_hit;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_adr;
  logic [31:0] mem_wdata;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  integer      seed;
  int          cycles;
  int          value_errors;
  int          proto_errors;
  int          read_beats;
  int          write_beats;

  // Words stored by write beats, everything else reads the fill pattern
  logic [31:0] written [logic [31:0]];

  l1d_top dut (
    .clk(clk), .rst_n(rst_n),
    .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_adr(cpu_adr),
    .cpu_wdata(cpu_wdata), .cpu_inv(cpu_inv),
    .busy(busy), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .cpu_hit(cpu_hit),
    .mem_req(mem_req), .mem_we(mem_we), .mem_adr(mem_adr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

  // ============================================================
  // Clock, cycle limit and memory model
  // ============================================================

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  // Current memory contents of a word address
  function automatic logic [31:0] model_word(input logic [31:0] adr);
    if (written.exists(adr))
      return written[adr];
    return adr ^ 32'h5a5a0000;
  endfunction

  // One beat per request, after 0 to 3 wait cycles, with a one-cycle ack
  initial
  begin : memory_model
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (mem_req)
      begin
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(posedge clk);
          #1;
        end
        if (mem_we)
        begin
          written[mem_adr] = mem_wdata;
          write_beats++;
        end
        else
        begin
          mem_rdata = model_word(mem_adr);
          read_beats++;
        end
        mem_ack = 1'b1;
        @(posedge clk);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  // ============================================================
  // Protocol assertions
  // ============================================================

  // The acknowledge never lasts longer than one cycle
  assert property (@(posedge clk) disable iff (!rst_n) !(cpu_ack && $past(cpu_ack)))
    else
    begin
      proto_errors++;
      $display("[ERROR] %0t cpu_ack stayed high for more than one cycle", $time);
    end

  // An unanswered memory request keeps its address and direction
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(mem_req && !mem_ack) |->
      (mem_req && mem_adr == $past(mem_adr) && mem_we == $past(mem_we)))
    else
    begin
      proto_errors++;
      $display("[ERROR] %0t mem_req dropped or changed before mem_ack", $time);
    end

  // Two cycles after a read strobe the ack is there exactly when it hit
  assert property (@(posedge clk) disable iff (!rst_n) $past(cpu_rd, 2) |-> cpu_ack == cpu_hit)
    else
    begin
      proto_errors++;
      $display("[ERROR] %0t read hit ack not two cycles after strobe", $time);
    end

  // Busy goes high on the cycle after a request strobe
  assert property (@(posedge clk) disable iff (!rst_n) (cpu_rd || cpu_wr) |=> busy)
    else
    begin
      proto_errors++;
      $display("[ERROR] %0t busy did not rise after a request strobe", $time);
    end

  // Busy ends on exactly the cycle that carries the acknowledge
  assert property (@(posedge clk) disable iff (!rst_n) cpu_ack == $fell(busy))
    else
    begin
      proto_errors++;
      $display("[ERROR] %0t busy did not fall together with cpu_ack", $time);
    end

  // ============================================================
  // CPU side tasks
  // ============================================================

  function automatic logic [31:0] line_addr(input int tag, input int set, input int word);
    phys_addr_u a;
    a.f.line     = tag_t'(tag * `L1D_SETS + set);
    a.f.word     = word[3:0];
    a.f.byte_sel = 2'b00;
    return a.raw;
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else
      begin
        value_errors++;
        $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      end
  endtask

  // Each task starts 1 ns after a rising edge and returns the same way
  task automatic issue_access(input logic wr, input logic [31:0] adr,
                              input logic [31:0] wdata);
    cpu_adr   = adr;
    cpu_wdata = wdata;
    cpu_rd    = !wr;
    cpu_wr    = wr;
    @(posedge clk);
    #1;
    cpu_rd = 1'b0;
    cpu_wr = 1'b0;
    while (!cpu_ack)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // A negative expectation means the value is not checked
  task automatic check_read(input string what, input logic [31:0] adr,
                            input int exp_hit, input int exp_beats);
    int beats_before;
    beats_before = read_beats;
    issue_access(1'b0, adr, 32'h0);
    expect_equal({what, " data"}, cpu_rdata, model_word(adr));
    if (exp_hit >= 0)
      expect_equal({what, " hit"}, 32'(cpu_hit), 32'(exp_hit));
    if (exp_beats >= 0)
      expect_equal({what, " read beats"}, 32'(read_beats - beats_before), 32'(exp_beats));
  endtask

  // Hit or miss, a store is one write beat and never a refill
  task automatic check_write(input string what, input logic [31:0] adr,
                             input logic [31:0] data);
    int reads_before;
    int writes_before;
    reads_before  = read_beats;
    writes_before = write_beats;
    issue_access(1'b1, adr, data);
    expect_equal({what, " write beats"}, 32'(write_beats - writes_before), 32'd1);
    expect_equal({what, " read beats"}, 32'(read_beats - reads_before), 32'd0);
    expect_equal({what, " memory"}, model_word(adr), data);
  endtask

  task automatic pulse_invalidate();
    cpu_inv = 1'b1;
    @(posedge clk);
    #1;
    cpu_inv = 1'b0;
  endtask

  // Operations are drawn first, so the memory model owns the seed later
  task automatic random_mix();
    logic        op_wr  [RAND_OPS];
    logic [31:0] op_adr [RAND_OPS];
    logic [31:0] op_dat [RAND_OPS];
    logic [31:0] r;
    for (int i = 0; i < RAND_OPS; i++)
    begin
      r         = $random(seed);
      op_wr[i]  = r[0];
      op_adr[i] = line_addr(40 + int'(r[15:8]) % 6, 16 + int'(r[3:1]), int'(r[7:4]));
      op_dat[i] = $random(seed);
    end
    for (int i = 0; i < RAND_OPS; i++)
    begin
      if (op_wr[i])
        check_write("random write", op_adr[i], op_dat[i]);
      else
        check_read("random read", op_adr[i], -1, -1);
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial
  begin
    seed         = 32'h36c3;
    cycles       = 0;
    value_errors = 0;
    proto_errors = 0;
    read_beats   = 0;
    write_beats  = 0;
    rst_n        = 1'b0;
    cpu_rd       = 1'b0;
    cpu_wr       = 1'b0;
    cpu_adr      = '0;
    cpu_wdata    = '0;
    cpu_inv      = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Miss and refill, then another word of the same line hits
    check_read("first miss", line_addr(1, 1, 3), 0, 16);
    check_read("same line", line_addr(1, 1, 9), 1, 0);

    // Store to a cached word goes to both the line and memory
    check_write("write hit", line_addr(1, 1, 9), 32'hcafe0009);
    check_read("read after write hit", line_addr(1, 1, 9), 1, 0);

    // Store to an absent line leaves the cache untouched
    check_write("write miss", line_addr(3, 2, 4), 32'h0badf00d);
    check_read("read after write miss", line_addr(3, 2, 4), 0, 16);

    // Lines 10 to 13 fill ways 0 to 3, touching line 10 makes way 2 the victim
    for (int t = 10; t < 14; t++)
      check_read("set fill", line_addr(t, 5, 0), 0, 16);
    check_read("touch A", line_addr(10, 5, 1), 1, 0);
    check_read("line E", line_addr(14, 5, 2), 0, 16);
    check_read("A kept", line_addr(10, 5, 3), 1, 0);
    check_read("B kept", line_addr(11, 5, 4), 1, 0);
    check_read("D kept", line_addr(13, 5, 5), 1, 0);
    check_read("C evicted", line_addr(12, 5, 6), 0, 16);

    // All lines are gone after an invalidate
    pulse_invalidate();
    check_read("after invalidate", line_addr(1, 1, 9), 0, 16);

    random_mix();

    $display("Summary: %0d value errors, %0d protocol errors", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* l1d.f */
+incdir+logic
logic/l1d_pkg.sv
logic/l1d_tag_store.sv
logic/l1d_hit_detect.sv
logic/l1d_data_array.sv
logic/l1d_plru.sv
logic/l1d_ctrl.sv
logic/l1d_top.sv
dv/l1d_tb.sv

/* logic/l1d_config.svh */
/*
 * Build constants of the l1d data cache.
 * Included by the package and by every module that sizes a port or an array.
 */
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Byte address width seen on both the CPU and the memory side
`define L1D_AWID 32

// Geometry of the cache, which is 128 sets of four 64-byte lines
`define L1D_SETS 128
`define L1D_WAYS 4
`define L1D_LINE_WORDS 16

// The tag is the whole line address, so the set index is part of it
`define L1D_TAG_W (`L1D_AWID - 6)

`endif

/* logic/l1d_ctrl.sv */
/*
 * Request sequencer of the cache. Registers a CPU strobe, looks it up,
 * refills a missed line in sixteen memory beats, and writes stores through.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_ctrl (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                cpu_rd,
  input  wire                                cpu_wr,
  input  wire  [`L1D_AWID-1:0]               cpu_adr,
  input  wire  [31:0]                        cpu_wdata,
  input  wire                                cpu_inv,
  output logic                               busy,
  output logic                               cpu_ack,
  output logic [31:0]                        cpu_rdata,
  output logic                               cpu_hit,
  output logic                               mem_req,
  output logic                               mem_we,
  output logic [`L1D_AWID-1:0]               mem_adr,
  output logic [31:0]                        mem_wdata,
  input  wire                                mem_ack,
  input  wire  [31:0]                        mem_rdata,
  output logic [$clog2(`L1D_SETS)-1:0]       index,
  output l1d_pkg::tag_t                      line_tag,
  input  wire                                hit,
  input  wire  l1d_pkg::way_t                rway,
  input  wire  l1d_pkg::way_t                victim,
  output logic                               fill,
  output l1d_pkg::way_t                      fill_way,
  output logic                               inv_all,
  output logic                               touch,
  output l1d_pkg::way_t                      touch_way,
  output logic                               d_rd,
  output logic                               d_wr,
  output l1d_pkg::way_t                      d_way,
  output logic [$clog2(`L1D_LINE_WORDS)-1:0] d_word,
  output logic [31:0]                        d_wdata,
  input  wire  [31:0]                        d_rdata
);
  import l1d_pkg::*;

  localparam int IDX_W  = $clog2(`L1D_SETS);
  localparam int WORD_W = $clog2(`L1D_LINE_WORDS);

  ctrl_state_e       state;
  phys_addr_u        req;
  logic [31:0]       wdata_q;
  logic              is_wr;
  logic [WORD_W-1:0] beat;
  way_t              fill_way_q;
  logic              beat_ack;
  logic              last_beat;

  // ============================================================
  // Request capture
  // ============================================================

  // Address and store data are only taken when the cache is free
  always_ff @(posedge clk)
  begin
    if (state == IDLE && (cpu_rd || cpu_wr))
    begin
      req.raw <= cpu_adr;
      wdata_q <= cpu_wdata;
    end
  end

  // ============================================================
  // State machine
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      is_wr      <= 1'b0;
      beat       <= '0;
      fill_way_q <= '0;
      mem_req    <= 1'b0;
      cpu_ack    <= 1'b0;
      cpu_hit    <= 1'b0;
    end
    else
    begin
      cpu_ack <= 1'b0;
      case (state)
        IDLE:
          if (cpu_rd || cpu_wr)
          begin
            is_wr <= cpu_wr;
            state <= LOOKUP;
          end
        LOOKUP:
        begin
          // The hit result is reported later with the acknowledge
          cpu_hit    <= hit;
          fill_way_q <= victim;
          beat       <= '0;
          if (is_wr)
            state <= WTHRU;
          else if (hit)
          begin
            cpu_ack <= 1'b1;
            state   <= IDLE;
          end
          else
            state <= REFILL;
        end
        REFILL:
          // Request low for a cycle between beats, then the next word
          if (!mem_req)
            mem_req <= 1'b1;
          else if (mem_ack)
          begin
            mem_req <= 1'b0;
            beat    <= beat + 1'b1;
            if (last_beat)
              state <= RFILL_DONE;
          end
        RFILL_DONE:
        begin
          // Requested word is read this cycle and shows up with the ack
          cpu_ack <= 1'b1;
          state   <= IDLE;
        end
        WTHRU:
          if (!mem_req)
            mem_req <= 1'b1;
          else if (mem_ack)
          begin
            mem_req <= 1'b0;
            cpu_ack <= 1'b1;
            state   <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // ============================================================
  // Datapath steering
  // ============================================================

  always_comb
  begin
    busy      = (state != IDLE);
    index     = req.f.line[IDX_W-1:0];
    line_tag  = req.f.line;
    beat_ack  = (state == REFILL) && mem_req && mem_ack;
    last_beat = (beat == WORD_W'(`L1D_LINE_WORDS - 1));

    // Tag and valid go in with the last refill word
    fill     = beat_ack && last_beat;
    fill_way = fill_way_q;
    inv_all  = cpu_inv && !busy;

    // Any hit or a completed refill marks the way as recently used
    touch     = fill || (state == LOOKUP && hit);
    touch_way = (state == REFILL) ? fill_way_q : rway;

    // Reads on a read hit and after a refill, writes per beat and on a write hit
    d_rd    = (state == LOOKUP && !is_wr && hit) || (state == RFILL_DONE);
    d_wr    = beat_ack || (state == LOOKUP && is_wr && hit);
    d_way   = (state == LOOKUP) ? rway : fill_way_q;
    d_word  = (state == REFILL) ? beat : req.f.word;
    d_wdata = (state == REFILL) ? mem_rdata : wdata_q;

    // Memory side uses word-aligned addresses
    mem_we    = (state == WTHRU);
    mem_adr   = {req.f.line, (mem_we ? req.f.word : beat), 2'b00};
    mem_wdata = wdata_q;
    cpu_rdata = d_rdata;
  end

endmodule

`default_nettype wire

/* logic/l1d_data_array.sv */
/*
 * Line data of all ways, one 32-bit word per location.
 * The word is selected by way, set and word offset, and a read lands a cycle later.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_data_array (
  input  wire                                clk,
  input  wire                                rd,
  input  wire                                wr,
  input  wire  l1d_pkg::way_t                way,
  input  wire  [$clog2(`L1D_SETS)-1:0]       index,
  input  wire  [$clog2(`L1D_LINE_WORDS)-1:0] word,
  input  wire  [31:0]                        wdata,
  output logic [31:0]                        rdata
);

  // ============================================================
  // Word memory
  // ============================================================

  localparam int DEPTH  = `L1D_WAYS * `L1D_SETS * `L1D_LINE_WORDS;
  localparam int ADDR_W = $clog2(DEPTH);

  logic [31:0]       mem [DEPTH];
  logic [ADDR_W-1:0] addr;

  // Way in the top bits, so each way occupies one contiguous block
  assign addr = {way, index, word};

  // A read in the same cycle as a write to that word returns the old word
  always_ff @(posedge clk)
  begin
    if (wr)
      mem[addr] <= wdata;
    // rdata holds between reads, so the CPU sees a steady value
    if (rd)
      rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* logic/l1d_hit_detect.sv */
/*
 * Compares the tag of each way of the set with the request line address.
 * Gives the hit vector, the hit flag and the way that feeds the data path.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_hit_detect (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire l1d_pkg::tag_t [`L1D_WAYS-1:0] way_tags,
  input  wire  [`L1D_WAYS-1:0]           way_valid,
  input  wire  l1d_pkg::tag_t            line_tag,
  output logic [`L1D_WAYS-1:0]           hits,
  output logic                           hit,
  output l1d_pkg::way_t                  rway
);
  import l1d_pkg::*;

  // Way chosen in the last cycle
  way_t prev_rway;

  // A way only matches while its line is valid
  // The full line address is compared, so the index bits are redundant here
  always_comb
  begin
    for (int w = 0; w < `L1D_WAYS; w++)
      hits[w] = way_valid[w] && (way_tags[w] == line_tag);
  end

  assign hit = |hits;

  // The lowest hitting way wins, scanning down so it is assigned last
  // With no hit the previous way is kept and the data path stays put
  always_comb
  begin
    rway = prev_rway;
    for (int w = `L1D_WAYS - 1; w >= 0; w--)
    begin
      if (hits[w])
        rway = way_t'(w);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      prev_rway <= '0;
    else
      prev_rway <= rway;
  end

endmodule

`default_nettype wire

/* logic/l1d_pkg.sv */
/*
 * Shared types of the l1d data cache: address views, tag and way numbers,
 * and the controller states. Modules import it inside their bodies.
 */
`default_nettype none

`include "l1d_config.svh"

package l1d_pkg;

  // A full line address, used as the tag
  typedef logic [`L1D_TAG_W-1:0] tag_t;

  // Way number inside a set
  typedef logic [$clog2(`L1D_WAYS)-1:0] way_t;

  // Field view of a byte address, where the set index is the low bits of line
  typedef struct packed {
    tag_t                                line;
    logic [$clog2(`L1D_LINE_WORDS)-1:0]  word;
    logic [1:0]                          byte_sel;
  } addr_fields_t;

  // The request address is read both as a raw word and as fields
  typedef union packed {
    logic [`L1D_AWID-1:0] raw;
    addr_fields_t         f;
  } phys_addr_u;

  // Controller sequence for one request
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    RFILL_DONE,
    WTHRU
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/l1d_plru.sv */
/*
 * Tree pseudo-LRU of three bits per set and the victim choice for refills.
 * Bit 0 picks a pair of ways, bits 1 and 2 pick a way inside pair 0-1 or 2-3.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_plru (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  [$clog2(`L1D_SETS)-1:0]  index,
  input  wire                           touch,
  input  wire  l1d_pkg::way_t           touch_way,
  input  wire  [`L1D_WAYS-1:0]          way_valid,
  output l1d_pkg::way_t                 victim
);
  import l1d_pkg::*;

  // Tree bits of each set, all zero after reset
  logic [2:0] tree_q [`L1D_SETS];
  logic [2:0] cur;

  assign cur = tree_q[index];

  // ============================================================
  // Update on use
  // ============================================================

  // The root turns to the other pair and the pair bit to the sibling way
  // Bits of the other pair keep their value
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < `L1D_SETS; s++)
        tree_q[s] <= '0;
    end
    else if (touch)
    begin
      tree_q[index][0] <= ~touch_way[1];
      if (touch_way[1])
        tree_q[index][2] <= ~touch_way[0];
      else
        tree_q[index][1] <= ~touch_way[0];
    end
  end

  // ============================================================
  // Victim selection
  // ============================================================

  // Follow the tree, unless a way is still empty
  // The downward scan leaves the lowest invalid way as the answer
  always_comb
  begin
    victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
    for (int w = `L1D_WAYS - 1; w >= 0; w--)
    begin
      if (!way_valid[w])
        victim = way_t'(w);
    end
  end

endmodule

`default_nettype wire

/* logic/l1d_tag_store.sv */
/*
 * Tags and valid bits of every set and way. The current set is read
 * combinationally, a refill writes one way, and invalidate clears all valids.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_tag_store (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire  [$clog2(`L1D_SETS)-1:0]        index,
  output l1d_pkg::tag_t [`L1D_WAYS-1:0]       way_tags,
  output logic [`L1D_WAYS-1:0]                way_valid,
  input  wire                                 fill,
  input  wire  l1d_pkg::way_t                 fill_way,
  input  wire  l1d_pkg::tag_t                 fill_tag,
  input  wire                                 inv_all
);
  import l1d_pkg::*;

  // ============================================================
  // Storage
  // ============================================================

  // Tag words carry no reset and only mean something when valid
  tag_t                 tags    [`L1D_SETS][`L1D_WAYS];
  logic [`L1D_WAYS-1:0] valid_q [`L1D_SETS];

  // A completed refill records the line address of the new line
  always_ff @(posedge clk)
  begin
    if (fill)
      tags[index][fill_way] <= fill_tag;
  end

  // Valid bits are control state
  // Invalidate wins over a fill arriving in the same cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < `L1D_SETS; s++)
        valid_q[s] <= '0;
    end
    else if (inv_all)
    begin
      for (int s = 0; s < `L1D_SETS; s++)
        valid_q[s] <= '0;
    end
    else if (fill)
      valid_q[index][fill_way] <= 1'b1;
  end

  // ============================================================
  // Read of the addressed set
  // ============================================================

  always_comb
  begin
    for (int w = 0; w < `L1D_WAYS; w++)
      way_tags[w] = tags[index][w];
  end

  assign way_valid = valid_q[index];

endmodule

`default_nettype wire

/* logic/l1d_top.sv */
/*
 * Top level of the l1d data cache, between a load/store unit and a word memory.
 * Holds the controller, tag store, hit compare, data array and pseudo-LRU.
 */
`timescale 1ns/1ns
`default_nettype none

`include "l1d_config.svh"

module l1d_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   cpu_rd,
  input  wire                   cpu_wr,
  input  wire  [`L1D_AWID-1:0]  cpu_adr,
  input  wire  [31:0]           cpu_wdata,
  input  wire                   cpu_inv,
  output logic                  busy,
  output logic                  cpu_ack,
  output logic [31:0]           cpu_rdata,
  output logic                  cpu_hit,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [`L1D_AWID-1:0]  mem_adr,
  output logic [31:0]           mem_wdata,
  input  wire                   mem_ack,
  input  wire  [31:0]           mem_rdata
);
  import l1d_pkg::*;

  // ============================================================
  // Internal connections
  // ============================================================

  logic [$clog2(`L1D_SETS)-1:0]       index;
  tag_t                               line_tag;
  tag_t [`L1D_WAYS-1:0]               way_tags;
  logic [`L1D_WAYS-1:0]               way_valid;
  logic                               hit;
  way_t                               rway;
  way_t                               victim;
  logic                               fill;
  way_t                               fill_way;
  logic                               inv_all;
  logic                               touch;
  way_t                               touch_way;
  logic                               d_rd;
  logic                               d_wr;
  way_t                               d_way;
  logic [$clog2(`L1D_LINE_WORDS)-1:0] d_word;
  logic [31:0]                        d_wdata;
  logic [31:0]                        d_rdata;

  l1d_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_adr(cpu_adr),
    .cpu_wdata(cpu_wdata), .cpu_inv(cpu_inv),
    .busy(busy), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .cpu_hit(cpu_hit),
    .mem_req(mem_req), .mem_we(mem_we), .mem_adr(mem_adr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .index(index), .line_tag(line_tag), .hit(hit), .rway(rway), .victim(victim),
    .fill(fill), .fill_way(fill_way), .inv_all(inv_all),
    .touch(touch), .touch_way(touch_way),
    .d_rd(d_rd), .d_wr(d_wr), .d_way(d_way), .d_word(d_word),
    .d_wdata(d_wdata), .d_rdata(d_rdata)
  );

  // The refill tag is the line address of the pending request
  l1d_tag_store u_tag_store (
    .clk(clk), .rst_n(rst_n), .index(index),
    .way_tags(way_tags), .way_valid(way_valid),
    .fill(fill), .fill_way(fill_way), .fill_tag(line_tag), .inv_all(inv_all)
  );

  // Only the combined hit flag is needed here, the per-way vector stays open
  l1d_hit_detect u_hit_detect (
    .clk(clk), .rst_n(rst_n),
    .way_tags(way_tags), .way_valid(way_valid), .line_tag(line_tag),
    .hits(), .hit(hit), .rway(rway)
  );

  l1d_data_array u_data_array (
    .clk(clk), .rd(d_rd), .wr(d_wr), .way(d_way), .index(index),
    .word(d_word), .wdata(d_wdata), .rdata(d_rdata)
  );

  l1d_plru u_plru (
    .clk(clk), .rst_n(rst_n), .index(index),
    .touch(touch), .touch_way(touch_way), .way_valid(way_valid), .victim(victim)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the l1d cache testbench with Verilator, runs it into a log
# and fails when the log reports a failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module l1d_tb -f l1d.f -o l1d_sim

./obj_dir/l1d_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log
then
  exit 1
fi
exit 0
